// File: verilog/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

`default_nettype none

// byte address width on every AXI-lite channel
`define MEM_ADDR_W 32

// data word width, also the instruction width
`define MEM_DATA_W 32

// on-chip SRAM size in words, addresses wrap modulo this
`define MEM_DEPTH_WORDS 256

// cycles from ar acceptance to rvalid, at least 1
`define MEM_READ_LATENCY 2

`default_nettype wire

`endif

// File: verilog/mem_pkg.sv
`include "mem_config.svh"

`default_nettype none

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;  // byte address
    typedef logic [`MEM_DATA_W-1:0] data_t;

    // axi-lite channel payloads, valid/ready travel beside them
    typedef struct packed {
        addr_t addr;
    } axi_ar_t;

    typedef struct packed {
        data_t data;
    } axi_r_t;

    typedef struct packed {
        addr_t addr;
    } axi_aw_t;

    typedef struct packed {
        data_t data;
    } axi_w_t;

    typedef struct packed {
        addr_t pc;
        data_t instr;
    } fetch_out_t;

    typedef struct packed {
        logic  write;  // 1 = store, 0 = load
        addr_t addr;
        data_t wdata;
    } lsu_cmd_t;

    typedef enum logic [2:0] {
        arb_idle, arb_ifu_read, arb_lsu_read, arb_lsu_write, arb_release
    } arb_state_t;

    typedef enum logic [1:0] {
        ifu_idle, ifu_addr, ifu_data, ifu_emit
    } ifu_state_t;

    typedef enum logic [2:0] {
        lsu_idle, lsu_read_addr, lsu_read_data, lsu_write_req, lsu_write_resp
    } lsu_state_t;

endpackage

`default_nettype wire

// File: verilog/ifu_fetch.sv
`default_nettype none

module ifu_fetch import mem_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        fetch_en,
    input  wire        pc_load_valid,
    input  wire addr_t pc_load_addr,
    output axi_ar_t    ar,
    output logic       ar_valid,
    input  wire        ar_ready,
    input  wire axi_r_t r,
    input  wire        r_valid,
    output logic       r_ready,
    output logic       fetch_valid,
    output fetch_out_t fetch_out,
    input  wire        fetch_ready
);

    ifu_state_t state;
    addr_t      pc;
    logic       pend_valid;  // pc load waiting for a fetch boundary
    addr_t      pend_addr;
    addr_t      load_addr;
    logic       load_hit;

    // a load in this very cycle wins over an older pending one
    assign load_hit  = pc_load_valid || pend_valid;
    assign load_addr = pc_load_valid ? pc_load_addr : pend_addr;

    assign ar_valid    = (state == ifu_addr);
    assign ar.addr     = pc;
    assign r_ready     = (state == ifu_data);
    assign fetch_valid = (state == ifu_emit);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ifu_idle;
            pc         <= '0;
            pend_valid <= 1'b0;
        end else begin
            if (pc_load_valid)
                pend_valid <= 1'b1;
            case (state)
                ifu_idle: begin
                    // no fetch in flight, apply a load at once
                    if (load_hit) begin
                        pc         <= load_addr;
                        pend_valid <= 1'b0;
                    end
                    if (fetch_en)
                        state <= ifu_addr;
                end
                ifu_addr: if (ar_ready) state <= ifu_data;
                ifu_data: if (r_valid) state <= ifu_emit;
                ifu_emit: begin
                    if (fetch_ready) begin  // fetch boundary
                        pc         <= load_hit ? load_addr : pc + addr_t'(4);
                        pend_valid <= 1'b0;
                        state      <= fetch_en ? ifu_addr : ifu_idle;
                    end
                end
                default: state <= ifu_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pc_load_valid)
            pend_addr <= pc_load_addr;
        if (r_valid && r_ready) begin
            fetch_out.pc    <= pc;
            fetch_out.instr <= r.data;
        end
    end

    // address held steady until the arbiter and slave take it
    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));

endmodule

`default_nettype wire

// File: verilog/lsu_access.sv
`default_nettype none

module lsu_access import mem_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire lsu_cmd_t cmd,
    input  wire          cmd_valid,
    output logic         cmd_ready,
    output axi_ar_t      ar,
    output logic         ar_valid,
    input  wire          ar_ready,
    input  wire axi_r_t  r,
    input  wire          r_valid,
    output logic         r_ready,
    output axi_aw_t      aw,
    output logic         aw_valid,
    input  wire          aw_ready,
    output axi_w_t       w,
    output logic         w_valid,
    input  wire          w_ready,
    input  wire          b_valid,
    output logic         b_ready,
    output logic         resp_valid,
    output data_t        resp_data
);

    lsu_state_t state;
    lsu_cmd_t   cmd_q;  // command being worked on

    assign ar_valid = (state == lsu_read_addr);
    assign ar.addr  = cmd_q.addr;
    assign r_ready  = (state == lsu_read_data);
    assign aw_valid = (state == lsu_write_req);
    assign w_valid  = (state == lsu_write_req);  // aw and w go out together
    assign aw.addr  = cmd_q.addr;
    assign w.data   = cmd_q.wdata;
    assign b_ready  = (state == lsu_write_resp);

    // cmd_ready is a flop so it stays low through reset
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= lsu_idle;
            cmd_ready  <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                lsu_idle: begin
                    cmd_ready <= 1'b1;
                    if (cmd_valid && cmd_ready) begin
                        cmd_ready <= 1'b0;
                        state     <= cmd.write ? lsu_write_req : lsu_read_addr;
                    end
                end
                lsu_read_addr: if (ar_ready) state <= lsu_read_data;
                lsu_read_data: begin
                    if (r_valid) begin
                        state      <= lsu_idle;
                        cmd_ready  <= 1'b1;
                        resp_valid <= 1'b1;
                    end
                end
                lsu_write_req: if (aw_ready && w_ready) state <= lsu_write_resp;
                lsu_write_resp: begin
                    if (b_valid) begin
                        state      <= lsu_idle;
                        cmd_ready  <= 1'b1;
                        resp_valid <= 1'b1;
                    end
                end
                default: state <= lsu_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready)
            cmd_q <= cmd;
        if (r_valid && r_ready)
            resp_data <= r.data;
        else if (b_valid && b_ready)
            resp_data <= '0;  // writes report zero
    end

    // aw and w stay up together with steady payload until both are taken
    a_aw_w_paired: assert property (@(posedge clk) disable iff (rst)
        aw_valid && w_valid && !(aw_ready && w_ready)
            |=> aw_valid && w_valid && $stable(aw) && $stable(w));

endmodule

`default_nettype wire

// File: verilog/axi_arbiter.sv
`default_nettype none

module axi_arbiter import mem_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    // fetch unit, read only
    input  wire axi_ar_t ifu_ar,
    input  wire          ifu_ar_valid,
    output logic         ifu_ar_ready,
    output axi_r_t       ifu_r,
    output logic         ifu_r_valid,
    input  wire          ifu_r_ready,
    // load/store unit
    input  wire axi_ar_t lsu_ar,
    input  wire          lsu_ar_valid,
    output logic         lsu_ar_ready,
    output axi_r_t       lsu_r,
    output logic         lsu_r_valid,
    input  wire          lsu_r_ready,
    input  wire axi_aw_t lsu_aw,
    input  wire          lsu_aw_valid,
    output logic         lsu_aw_ready,
    input  wire axi_w_t  lsu_w,
    input  wire          lsu_w_valid,
    output logic         lsu_w_ready,
    output logic         lsu_b_valid,
    input  wire          lsu_b_ready,
    // memory slave
    output axi_ar_t      mem_ar,
    output logic         mem_ar_valid,
    input  wire          mem_ar_ready,
    input  wire axi_r_t  mem_r,
    input  wire          mem_r_valid,
    output logic         mem_r_ready,
    output axi_aw_t      mem_aw,
    output logic         mem_aw_valid,
    input  wire          mem_aw_ready,
    output axi_w_t       mem_w,
    output logic         mem_w_valid,
    input  wire          mem_w_ready,
    input  wire          mem_b_valid,
    output logic         mem_b_ready
);

    arb_state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_idle;
        end else begin
            case (state)
                arb_idle: begin  // fixed priority: ifu read, lsu read, lsu write
                    if (ifu_ar_valid)
                        state <= arb_ifu_read;
                    else if (lsu_ar_valid)
                        state <= arb_lsu_read;
                    else if (lsu_aw_valid || lsu_w_valid)
                        state <= arb_lsu_write;
                end
                arb_ifu_read:  if (mem_r_valid && ifu_r_ready) state <= arb_release;
                arb_lsu_read:  if (mem_r_valid && lsu_r_ready) state <= arb_release;
                arb_lsu_write: if (mem_b_valid && lsu_b_ready) state <= arb_release;
                arb_release:   state <= arb_idle;  // one dead cycle between grants
                default:       state <= arb_idle;
            endcase
        end
    end

    // routing follows the registered grant only
    always_comb begin
        mem_ar       = '0;
        mem_ar_valid = 1'b0;
        mem_r_ready  = 1'b0;
        mem_aw       = '0;
        mem_aw_valid = 1'b0;
        mem_w        = '0;
        mem_w_valid  = 1'b0;
        mem_b_ready  = 1'b0;
        ifu_ar_ready = 1'b0;
        ifu_r        = '0;
        ifu_r_valid  = 1'b0;
        lsu_ar_ready = 1'b0;
        lsu_r        = '0;
        lsu_r_valid  = 1'b0;
        lsu_aw_ready = 1'b0;
        lsu_w_ready  = 1'b0;
        lsu_b_valid  = 1'b0;
        case (state)
            arb_ifu_read: begin
                mem_ar       = ifu_ar;
                mem_ar_valid = ifu_ar_valid;
                ifu_ar_ready = mem_ar_ready;
                ifu_r        = mem_r;
                ifu_r_valid  = mem_r_valid;
                mem_r_ready  = ifu_r_ready;
            end
            arb_lsu_read: begin
                mem_ar       = lsu_ar;
                mem_ar_valid = lsu_ar_valid;
                lsu_ar_ready = mem_ar_ready;
                lsu_r        = mem_r;
                lsu_r_valid  = mem_r_valid;
                mem_r_ready  = lsu_r_ready;
            end
            arb_lsu_write: begin
                mem_aw       = lsu_aw;
                mem_aw_valid = lsu_aw_valid;
                lsu_aw_ready = mem_aw_ready;
                mem_w        = lsu_w;
                mem_w_valid  = lsu_w_valid;
                lsu_w_ready  = mem_w_ready;
                lsu_b_valid  = mem_b_valid;
                mem_b_ready  = lsu_b_ready;
            end
            default: ;  // idle and release drive nothing
        endcase
    end

    // one read address per grant, none follows before the data returns
    a_one_ar_per_grant: assert property (@(posedge clk) disable iff (rst)
        mem_ar_valid && mem_ar_ready |=> !mem_ar_valid);

endmodule

`default_nettype wire

// File: verilog/sram_slave.sv
`include "mem_config.svh"

`default_nettype none

module sram_slave import mem_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire axi_ar_t ar,
    input  wire          ar_valid,
    output logic         ar_ready,
    output axi_r_t       r,
    output logic         r_valid,
    input  wire          r_ready,
    input  wire axi_aw_t aw,
    input  wire          aw_valid,
    output logic         aw_ready,
    input  wire axi_w_t  w,
    input  wire          w_valid,
    output logic         w_ready,
    output logic         b_valid,
    input  wire          b_ready
);

    localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);
    localparam int LAT   = `MEM_READ_LATENCY;
    localparam int CNT_W = $clog2(LAT + 1);

    data_t            mem [`MEM_DEPTH_WORDS];
    logic             rd_pend;  // read accepted, data not yet taken
    logic [CNT_W-1:0] rd_cnt;
    data_t            rd_data;
    logic             idle;
    logic             ar_fire;
    logic             wr_fire;

    assign idle     = !rd_pend && !b_valid;
    assign ar_ready = idle;
    assign aw_ready = idle && !ar_valid;  // read wins a tie
    assign w_ready  = aw_ready;
    assign ar_fire  = ar_valid && ar_ready;
    assign wr_fire  = aw_valid && w_valid && aw_ready;

    assign r_valid = rd_pend && (rd_cnt == CNT_W'(LAT));
    assign r.data  = rd_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
            rd_cnt  <= '0;
            b_valid <= 1'b0;
        end else begin
            if (ar_fire) begin
                rd_pend <= 1'b1;
                rd_cnt  <= CNT_W'(1);
            end else if (r_valid && r_ready) begin
                rd_pend <= 1'b0;
            end else if (rd_pend && !r_valid) begin
                rd_cnt <= rd_cnt + CNT_W'(1);  // count out the latency
            end
            if (wr_fire)
                b_valid <= 1'b1;
            else if (b_ready)
                b_valid <= 1'b0;
        end
    end

    // word index is the address above the byte offset
    always_ff @(posedge clk) begin
        if (ar_fire)
            rd_data <= mem[ar.addr[IDX_W+1:2]];
        if (wr_fire)
            mem[aw.addr[IDX_W+1:2]] <= w.data;
    end

    a_w_needs_aw: assert property (@(posedge clk) disable iff (rst)
        w_valid |-> aw_valid);

endmodule

`default_nettype wire

// File: verilog/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top import mem_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           fetch_en,
    input  wire           pc_load_valid,
    input  wire addr_t    pc_load_addr,
    output logic          fetch_valid,
    output fetch_out_t    fetch_out,
    input  wire           fetch_ready,
    input  wire           lsu_cmd_valid,
    input  wire lsu_cmd_t lsu_cmd,
    output logic          lsu_cmd_ready,
    output logic          lsu_resp_valid,
    output data_t         lsu_resp_data
);

    // fetch unit to arbiter
    axi_ar_t ifu_ar;
    axi_r_t  ifu_r;
    logic    ifu_ar_valid, ifu_ar_ready, ifu_r_valid, ifu_r_ready;

    // load/store unit to arbiter
    axi_ar_t lsu_ar;
    axi_r_t  lsu_r;
    axi_aw_t lsu_aw;
    axi_w_t  lsu_w;
    logic    lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
    logic    lsu_aw_valid, lsu_aw_ready, lsu_w_valid, lsu_w_ready;
    logic    lsu_b_valid, lsu_b_ready;

    // arbiter to sram
    axi_ar_t mem_ar;
    axi_r_t  mem_r;
    axi_aw_t mem_aw;
    axi_w_t  mem_w;
    logic    mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
    logic    mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready;
    logic    mem_b_valid, mem_b_ready;

    ifu_fetch u_ifu (
        .clk, .rst, .fetch_en, .pc_load_valid, .pc_load_addr,
        .ar(ifu_ar), .ar_valid(ifu_ar_valid), .ar_ready(ifu_ar_ready),
        .r(ifu_r), .r_valid(ifu_r_valid), .r_ready(ifu_r_ready),
        .fetch_valid, .fetch_out, .fetch_ready
    );

    lsu_access u_lsu (
        .clk, .rst,
        .cmd(lsu_cmd), .cmd_valid(lsu_cmd_valid), .cmd_ready(lsu_cmd_ready),
        .ar(lsu_ar), .ar_valid(lsu_ar_valid), .ar_ready(lsu_ar_ready),
        .r(lsu_r), .r_valid(lsu_r_valid), .r_ready(lsu_r_ready),
        .aw(lsu_aw), .aw_valid(lsu_aw_valid), .aw_ready(lsu_aw_ready),
        .w(lsu_w), .w_valid(lsu_w_valid), .w_ready(lsu_w_ready),
        .b_valid(lsu_b_valid), .b_ready(lsu_b_ready),
        .resp_valid(lsu_resp_valid), .resp_data(lsu_resp_data)
    );

    axi_arbiter u_arb (
        .clk, .rst,
        .ifu_ar, .ifu_ar_valid, .ifu_ar_ready, .ifu_r, .ifu_r_valid, .ifu_r_ready,
        .lsu_ar, .lsu_ar_valid, .lsu_ar_ready, .lsu_r, .lsu_r_valid, .lsu_r_ready,
        .lsu_aw, .lsu_aw_valid, .lsu_aw_ready, .lsu_w, .lsu_w_valid, .lsu_w_ready,
        .lsu_b_valid, .lsu_b_ready,
        .mem_ar, .mem_ar_valid, .mem_ar_ready, .mem_r, .mem_r_valid, .mem_r_ready,
        .mem_aw, .mem_aw_valid, .mem_aw_ready, .mem_w, .mem_w_valid, .mem_w_ready,
        .mem_b_valid, .mem_b_ready
    );

    sram_slave u_sram (
        .clk, .rst,
        .ar(mem_ar), .ar_valid(mem_ar_valid), .ar_ready(mem_ar_ready),
        .r(mem_r), .r_valid(mem_r_valid), .r_ready(mem_r_ready),
        .aw(mem_aw), .aw_valid(mem_aw_valid), .aw_ready(mem_aw_ready),
        .w(mem_w), .w_valid(mem_w_valid), .w_ready(mem_w_ready),
        .b_valid(mem_b_valid), .b_ready(mem_b_ready)
    );

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

`default_nettype none

data_t model_mem [addr_t];  // keyed by wrapped word address
int    check_count = 0;
int    error_count = 0;
int    checks_mark = 0;     // counts when the current test started
int    errors_mark = 0;

// sram wraps modulo its depth, byte offset dropped
function automatic addr_t word_of(addr_t a);
    return a & addr_t'((`MEM_DEPTH_WORDS * 4) - 4);
endfunction

function automatic void model_write(addr_t a, data_t d);
    model_mem[word_of(a)] = d;
endfunction

function automatic data_t model_read(addr_t a);
    if (!model_mem.exists(word_of(a))) begin
        error_count++;
        $display("error: the test read address %h, which it never wrote", a);
        return '0;
    end
    return model_mem[word_of(a)];
endfunction

task automatic check_bit(input string sig, input logic got, input logic want);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("[FAIL] %0t ns %s: got %b, expected %b", $time, sig, got, want);
    end
endtask

task automatic check_data(input string sig, input data_t got, input data_t want);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("[FAIL] %0t ns %s: got %h, expected %h", $time, sig, got, want);
    end
endtask

task automatic check_fetch(input string sig, input fetch_out_t got, input fetch_out_t want);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("[FAIL] %0t ns %s: got pc %h instr %h, expected pc %h instr %h",
                 $time, sig, got.pc, got.instr, want.pc, want.instr);
    end
endtask

task automatic report_test(input string name);
    $display("%s: %0d checks, %0d errors", name,
             check_count - checks_mark, error_count - errors_mark);
    checks_mark = check_count;
    errors_mark = error_count;
endtask

`default_nettype wire

`endif

// File: testbench/tb_mem_subsys.sv
`include "mem_config.svh"

`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t REGION  = 32'h100;  // program words 64..79
    localparam int    LAT     = `MEM_READ_LATENCY;
    localparam int    LSU_MIX = 12;
    localparam int    NUM_OPS = 146;      // lsu ops plus fetched words over all tests
    localparam int    WATCHDOG_CYCLES = NUM_OPS * (2 * LAT + 10) + 500;

    logic        clk;
    logic        rst;
    logic        fetch_en;
    logic        pc_load_valid;
    addr_t       pc_load_addr;
    logic        fetch_valid;
    fetch_out_t  fetch_out;
    logic        fetch_ready;
    logic        lsu_cmd_valid;
    lsu_cmd_t    lsu_cmd;
    logic        lsu_cmd_ready;
    logic        lsu_resp_valid;
    data_t       lsu_resp_data;
    logic [31:0] lcg_state;

    `include "tb_mem_model.svh"

    mem_subsys_top UUT (
        .clk, .rst, .fetch_en, .pc_load_valid, .pc_load_addr,
        .fetch_valid, .fetch_out, .fetch_ready,
        .lsu_cmd_valid, .lsu_cmd, .lsu_cmd_ready, .lsu_resp_valid, .lsu_resp_data
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper half only, low lcg bits repeat quickly
    function automatic int rand_below(int n);
        logic [31:0] v;
        v = lcg_next();
        return int'(v[31:16]) % n;
    endfunction

    function automatic addr_t low_addr();
        return addr_t'(rand_below(64) * 4);  // below the program region
    endfunction

    task automatic lsu_op(input logic wr, input addr_t a, input data_t d, output data_t rd);
        lsu_cmd_t c;
        c.write = wr;
        c.addr  = a;
        c.wdata = d;
        @(negedge clk);
        while (!lsu_cmd_ready) @(negedge clk);
        lsu_cmd       = c;
        lsu_cmd_valid = 1'b1;
        @(negedge clk);                       // taken on the edge just passed
        lsu_cmd_valid = 1'b0;
        while (!lsu_resp_valid) @(negedge clk);
        rd = lsu_resp_data;
    endtask

    task automatic lsu_write_read(input addr_t a, input data_t d);
        data_t rd;
        lsu_op(1'b1, a, d, rd);
        model_write(a, d);
        check_data("lsu_resp_data", rd, '0);  // writes answer zero
        lsu_op(1'b0, a, '0, rd);
        check_data("lsu_resp_data", rd, model_read(a));
    endtask

    task automatic start_fetch(input addr_t start);
        @(negedge clk);
        pc_load_addr  = start;
        pc_load_valid = 1'b1;
        fetch_en      = 1'b1;
        @(negedge clk);
        pc_load_valid = 1'b0;
    endtask

    // word is recorded at the negedge, the transfer follows on the next posedge
    task automatic fetch_word(input int stall_pct, input logic last, output fetch_out_t word);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            fetch_en    = !last;              // stop after this word
            fetch_ready = rand_below(100) >= stall_pct;
            if (fetch_valid && fetch_ready) begin
                word  = fetch_out;
                taken = 1'b1;
            end
        end
    endtask

    task automatic fetch_run(input addr_t start, input int n, input int stall_pct);
        fetch_out_t got;
        fetch_out_t want;
        int         k;
        start_fetch(start);
        for (k = 0; k < n; k++) begin
            fetch_word(stall_pct, k == n - 1, got);
            want.pc    = start + addr_t'(4 * k);
            want.instr = model_read(want.pc);
            check_fetch("fetch_out", got, want);
        end
    endtask

    task automatic check_reset();
        check_bit("fetch_valid", fetch_valid, 1'b0);
        check_bit("lsu_resp_valid", lsu_resp_valid, 1'b0);
        check_bit("lsu_cmd_ready", lsu_cmd_ready, 1'b0);
        @(negedge clk);
        check_bit("lsu_cmd_ready", lsu_cmd_ready, 1'b1);
        check_bit("fetch_valid", fetch_valid, 1'b0);
    endtask

    task automatic load_program();
        data_t rd;
        data_t d;
        int    k;
        for (k = 0; k < 16; k++) begin
            d = lcg_next();
            lsu_op(1'b1, REGION + addr_t'(4 * k), d, rd);
            model_write(REGION + addr_t'(4 * k), d);
            check_data("lsu_resp_data", rd, '0);
        end
    endtask

    task automatic run_concurrent();
        addr_t mix_addr [LSU_MIX];
        data_t mix_data [LSU_MIX];
        int    i;
        // drawn up front so only the fetch thread touches the lcg
        for (i = 0; i < LSU_MIX; i++) begin
            mix_addr[i] = low_addr();
            mix_data[i] = lcg_next();
        end
        fork
            fetch_run(REGION, 16, 25);
            begin
                for (i = 0; i < LSU_MIX; i++)
                    lsu_write_read(mix_addr[i], mix_data[i]);
            end
        join
    endtask

    task automatic run_pc_jump();
        addr_t      jump;
        addr_t      exp_pc;
        logic       pend;
        fetch_out_t got;
        fetch_out_t want;
        int         k;
        jump   = REGION + addr_t'(32);
        exp_pc = REGION;
        pend   = 1'b0;
        start_fetch(REGION);
        for (k = 0; k < 10; k++) begin
            if (k == 3) begin
                @(negedge clk);
                fetch_ready   = 1'b0;         // hold the word in flight
                pc_load_addr  = jump;
                pc_load_valid = 1'b1;
                @(negedge clk);
                pc_load_valid = 1'b0;
                pend          = 1'b1;
            end
            fetch_word(25, k == 9, got);
            // at most one old word may still come out
            if (pend && got.pc != exp_pc) begin
                exp_pc = jump;
                pend   = 1'b0;
            end
            want.pc    = exp_pc;
            want.instr = model_read(exp_pc);
            check_fetch("fetch_out", got, want);
            if (pend) begin
                exp_pc = jump;
                pend   = 1'b0;
            end else begin
                exp_pc = exp_pc + addr_t'(4);
            end
        end
    endtask

    initial begin
        int i;
        lcg_state     = 32'he89d;
        rst           = 1'b1;
        fetch_en      = 1'b0;
        pc_load_valid = 1'b0;
        pc_load_addr  = '0;
        fetch_ready   = 1'b0;
        lsu_cmd_valid = 1'b0;
        lsu_cmd       = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_reset();
        report_test("reset state");
        for (i = 0; i < 24; i++)
            lsu_write_read(low_addr(), lcg_next());
        report_test("lsu write and read back");
        load_program();
        fetch_run(REGION, 16, 0);
        report_test("program fetch");
        fetch_run(REGION, 16, 50);
        report_test("fetch under back-pressure");
        run_concurrent();
        report_test("fetch with lsu traffic");
        run_pc_jump();
        report_test("pc load mid-stream");
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles, a handshake never completed",
                 WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_subsys_top.f
+incdir+verilog
+incdir+testbench
verilog/mem_pkg.sv
verilog/ifu_fetch.sv
verilog/lsu_access.sv
verilog/axi_arbiter.sv
verilog/sram_slave.sv
verilog/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, decide from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_subsys -f mem_subsys_top.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
